// File: include/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Group width and register file geometry
`define RN_WIDTH   3
`define ARCH_AW    5
`define ARCH_REGS  32
`define PHYS_AW    6
`define PHYS_REGS  64

// Load/store queue slots
`define LSQ_SLOTS  8
`define LSQ_AW     3

// RV32 major opcodes seen by rename
`define OPC_LOAD   7'b0000011
`define OPC_OP_IMM 7'b0010011
`define OPC_AUIPC  7'b0010111
`define OPC_STORE  7'b0100011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011
`define OPC_JALR   7'b1100111
`define OPC_JAL    7'b1101111

`endif

// File: logic/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

    typedef logic [`ARCH_AW-1:0] arch_reg_t;
    typedef logic [`PHYS_AW-1:0] phys_reg_t;
    typedef logic [`LSQ_AW-1:0]  lsq_id_t;

    // ======================================================================
    // Instruction word views
    // ======================================================================

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

    // Store layout, the rd bits hold the low immediate instead
    typedef struct packed {
        logic [6:0] imm_hi;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r_view;
        s_fields_t s_view;
    } inst_word_u;

    // ======================================================================
    // Slot records
    // ======================================================================

    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      rd_write;
        logic      load_store;
    } dec_slot_t;

    typedef struct packed {
        phys_reg_t rs1_phys;
        phys_reg_t rs2_phys;
        phys_reg_t rd_phys;
        phys_reg_t old_rd_phys;
        logic      rd_valid;
        logic      lsq_valid;
        lsq_id_t   lsq_slot;
    } ren_slot_t;

    // One register returned by the reorder buffer
    typedef struct packed {
        logic      valid;
        phys_reg_t free_phys;
    } commit_slot_t;

endpackage

// File: logic/rename_decode.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_decode
    import rename_pkg::*;
(
    input  inst_word_u [`RN_WIDTH-1:0] inst,
    input  logic       [`RN_WIDTH-1:0] inst_valid,
    output dec_slot_t  [`RN_WIDTH-1:0] dec
);

    // Pulls the register fields out of one word
    function automatic dec_slot_t decode_word(
        input inst_word_u word,
        input logic       valid
    );
        dec_slot_t  d;
        logic [6:0] opcode;
        logic       s_form;
        logic       no_rs1;

        opcode = word.r_view.opcode;

        // Stores and branches share the S register positions
        s_form = (opcode == `OPC_STORE) || (opcode == `OPC_BRANCH);
        no_rs1 = opcode inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL};

        d.valid      = valid;
        d.rd_write   = opcode inside {`OPC_OP, `OPC_OP_IMM, `OPC_LOAD, `OPC_LUI,
                                      `OPC_AUIPC, `OPC_JAL, `OPC_JALR};
        d.load_store = (opcode == `OPC_LOAD) || (opcode == `OPC_STORE);

        if (s_form) begin
            d.rs1 = word.s_view.rs1;
            d.rs2 = word.s_view.rs2;
        end else begin
            d.rs1 = no_rs1 ? '0 : word.r_view.rs1;
            // Only register-register ops carry rs2 here
            d.rs2 = (opcode == `OPC_OP) ? word.r_view.rs2 : '0;
        end

        // No destination means rd reads as x0
        d.rd = d.rd_write ? word.r_view.rd : '0;

        return d;
    endfunction

    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            dec[i] = decode_word(inst[i], inst_valid[i]);
        end
    end

endmodule

// File: logic/free_list.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_list #(
    parameter int DEPTH    = 32,
    parameter int ID_W     = 6,
    parameter int FIRST_ID = 32
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [`RN_WIDTH-1:0]           pop_req,
    output logic [`RN_WIDTH-1:0][ID_W-1:0] pop_id,
    output logic [`RN_WIDTH-1:0]           pop_ok,
    input  logic [`RN_WIDTH-1:0]           push_en,
    input  logic [`RN_WIDTH-1:0][ID_W-1:0] push_id,
    output logic [$clog2(DEPTH+1)-1:0]     count
);

    // DEPTH is a power of two, so head and tail wrap on their own
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ID_W-1:0]  entries [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    logic [CNT_W-1:0]                pop_cnt;
    logic [CNT_W-1:0]                push_cnt;
    logic [`RN_WIDTH-1:0]            push_take;
    logic [`RN_WIDTH-1:0][PTR_W-1:0] push_ptr;

    // ======================================================================
    // Pops, served in port order from consecutive head entries
    // ======================================================================

    always_comb begin
        logic [PTR_W-1:0] rd_ptr;

        pop_cnt = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            rd_ptr    = head + PTR_W'(pop_cnt);
            pop_id[i] = entries[rd_ptr];
            pop_ok[i] = pop_req[i] && (pop_cnt < count);
            if (pop_ok[i]) begin
                pop_cnt = pop_cnt + 1'b1;
            end
        end
    end

    // ======================================================================
    // Pushes, appended at the tail in port order
    // ======================================================================

    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            push_ptr[i] = tail + PTR_W'(push_cnt);
            // Drop anything that would overrun the buffer
            push_take[i] = push_en[i] &&
                           (int'(count) - int'(pop_cnt) + int'(push_cnt) < DEPTH);
            if (push_take[i]) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Starts full with FIRST_ID upward
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= ID_W'(FIRST_ID + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(DEPTH);
        end else begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (push_take[i]) begin
                    entries[push_ptr[i]] <= push_id[i];
                end
            end
            head  <= head + PTR_W'(pop_cnt);
            tail  <= tail + PTR_W'(push_cnt);
            count <= count + push_cnt - pop_cnt;
        end
    end

endmodule

// File: logic/register_alias_table.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module register_alias_table
    import rename_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  dec_slot_t    [`RN_WIDTH-1:0]   dec,
    input  commit_slot_t [`RN_WIDTH-1:0]   commit,
    output logic         [`RN_WIDTH-1:0]   reg_pop,
    input  phys_reg_t    [`RN_WIDTH-1:0]   reg_id,
    input  logic         [`RN_WIDTH-1:0]   reg_ok,
    output logic         [`RN_WIDTH-1:0]   reg_push,
    output phys_reg_t    [`RN_WIDTH-1:0]   reg_push_id,
    output logic         [`RN_WIDTH-1:0]   lsq_pop,
    input  lsq_id_t      [`RN_WIDTH-1:0]   lsq_id,
    input  logic         [`RN_WIDTH-1:0]   lsq_ok,
    output ren_slot_t    [`RN_WIDTH-1:0]   renamed
);

    // Architectural to physical map, entry 0 is never written
    phys_reg_t map_table [`ARCH_REGS];

    logic [`RN_WIDTH-1:0] alloc_ok;
    logic [`RN_WIDTH-1:0] lsq_got;

    // ======================================================================
    // Allocation requests
    // ======================================================================

    always_comb begin
        for (int j = 0; j < `RN_WIDTH; j++) begin
            reg_pop[j] = dec[j].valid && dec[j].rd_write && (dec[j].rd != '0);
            lsq_pop[j] = dec[j].valid && dec[j].load_store;
        end
    end

    // Grants only count where this slot asked
    assign alloc_ok = reg_pop & reg_ok;
    assign lsq_got  = lsq_pop & lsq_ok;

    // Commit hands freed registers back, physical 0 is never recycled
    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            reg_push[i]    = commit[i].valid && (commit[i].free_phys != '0);
            reg_push_id[i] = commit[i].free_phys;
        end
    end

    // ======================================================================
    // Source lookup with intra-group bypass
    // ======================================================================

    always_comb begin
        phys_reg_t rs1_map;
        phys_reg_t rs2_map;
        phys_reg_t old_map;

        for (int j = 0; j < `RN_WIDTH; j++) begin
            rs1_map = map_table[dec[j].rs1];
            rs2_map = map_table[dec[j].rs2];
            old_map = map_table[dec[j].rd];

            // Walk older slots oldest first so the newest match wins
            for (int k = 0; k < j; k++) begin
                if (alloc_ok[k]) begin
                    if (dec[k].rd == dec[j].rs1) begin
                        rs1_map = reg_id[k];
                    end
                    if (dec[k].rd == dec[j].rs2) begin
                        rs2_map = reg_id[k];
                    end
                    // Previous mapping is the older slot's new register
                    if (dec[k].rd == dec[j].rd) begin
                        old_map = reg_id[k];
                    end
                end
            end

            renamed[j].rs1_phys    = rs1_map;
            renamed[j].rs2_phys    = rs2_map;
            renamed[j].rd_valid    = alloc_ok[j];
            renamed[j].rd_phys     = alloc_ok[j] ? reg_id[j] : '0;
            renamed[j].old_rd_phys = alloc_ok[j] ? old_map : '0;
            renamed[j].lsq_valid   = lsq_got[j];
            renamed[j].lsq_slot    = lsq_got[j] ? lsq_id[j] : '0;
        end
    end

    // ======================================================================
    // Table update
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity map
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= phys_reg_t'(i);
            end
        end else begin
            // Slot order, so the youngest write to one rd lands last
            for (int j = 0; j < `RN_WIDTH; j++) begin
                if (alloc_ok[j]) begin
                    map_table[dec[j].rd] <= reg_id[j];
                end
            end
        end
    end

endmodule

// File: logic/rename_stage.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_stage
    import rename_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  inst_word_u   [`RN_WIDTH-1:0] inst,
    input  logic         [`RN_WIDTH-1:0] inst_valid,
    input  commit_slot_t [`RN_WIDTH-1:0] commit,
    input  logic                         lsq_free_valid,
    input  lsq_id_t                      lsq_free_slot,
    output ren_slot_t    [`RN_WIDTH-1:0] renamed,
    output logic         [`RN_WIDTH-1:0] rename_ready,
    output logic         [`RN_WIDTH-1:0] lsq_ready
);

    // Registers above the architectural range start out free
    localparam int PHYS_FREE_DEPTH = `PHYS_REGS - `ARCH_REGS;

    dec_slot_t [`RN_WIDTH-1:0] dec;

    logic      [`RN_WIDTH-1:0] reg_pop;
    phys_reg_t [`RN_WIDTH-1:0] reg_id;
    logic      [`RN_WIDTH-1:0] reg_ok;
    logic      [`RN_WIDTH-1:0] reg_push;
    phys_reg_t [`RN_WIDTH-1:0] reg_push_id;
    logic      [`RN_WIDTH-1:0] lsq_pop;
    lsq_id_t   [`RN_WIDTH-1:0] lsq_id;
    logic      [`RN_WIDTH-1:0] lsq_ok;

    logic [$clog2(PHYS_FREE_DEPTH+1)-1:0] phys_count;
    logic [$clog2(`LSQ_SLOTS+1)-1:0]      lsq_count;

    rename_decode u_decode (
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dec)
    );

    register_alias_table u_rat (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .commit      (commit),
        .reg_pop     (reg_pop),
        .reg_id      (reg_id),
        .reg_ok      (reg_ok),
        .reg_push    (reg_push),
        .reg_push_id (reg_push_id),
        .lsq_pop     (lsq_pop),
        .lsq_id      (lsq_id),
        .lsq_ok      (lsq_ok),
        .renamed     (renamed)
    );

    free_list #(
        .DEPTH    (PHYS_FREE_DEPTH),
        .ID_W     (`PHYS_AW),
        .FIRST_ID (`ARCH_REGS)
    ) phys_free_list (
        .clk     (clk),
        .reset   (reset),
        .pop_req (reg_pop),
        .pop_id  (reg_id),
        .pop_ok  (reg_ok),
        .push_en (reg_push),
        .push_id (reg_push_id),
        .count   (phys_count)
    );

    // Queue slots come back one at a time on port 0
    free_list #(
        .DEPTH    (`LSQ_SLOTS),
        .ID_W     (`LSQ_AW),
        .FIRST_ID (0)
    ) lsq_free_list (
        .clk     (clk),
        .reset   (reset),
        .pop_req (lsq_pop),
        .pop_id  (lsq_id),
        .pop_ok  (lsq_ok),
        .push_en ({{(`RN_WIDTH-1){1'b0}}, lsq_free_valid}),
        .push_id ({{((`RN_WIDTH-1)*`LSQ_AW){1'b0}}, lsq_free_slot}),
        .count   (lsq_count)
    );

    // Thermometer, bit i set when more than i entries are free
    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            rename_ready[i] = int'(phys_count) > i;
            lsq_ready[i]    = int'(lsq_count) > i;
        end
    end

endmodule

// File: dv/rename_assert.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_assert (
    input logic                 clk,
    input logic                 reset,
    input logic [`PHYS_AW-1:0]  map_zero,
    input logic [`RN_WIDTH-1:0] reg_pop,
    input logic [`RN_WIDTH-1:0] reg_ok,
    input logic [`RN_WIDTH-1:0] reg_push,
    input logic [`RN_WIDTH-1:0] lsq_pop,
    input logic [`RN_WIDTH-1:0] lsq_ok
);

    // Registers above the architectural range start out free
    localparam int FREE_START = `PHYS_REGS - `ARCH_REGS;

    int   free_regs;
    logic reg_order_bad;
    logic lsq_order_bad;

    // Shadow count of free physical registers
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            free_regs <= FREE_START;
        end else begin
            free_regs <= free_regs + $countones(reg_push) - $countones(reg_pop & reg_ok);
        end
    end

    always_comb begin
        logic reg_failed;
        logic lsq_failed;

        reg_failed    = 1'b0;
        lsq_failed    = 1'b0;
        reg_order_bad = 1'b0;
        lsq_order_bad = 1'b0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (reg_pop[i]) begin
                if (reg_ok[i] && reg_failed) begin
                    reg_order_bad = 1'b1;
                end
                if (!reg_ok[i]) begin
                    reg_failed = 1'b1;
                end
            end
            if (lsq_pop[i]) begin
                if (lsq_ok[i] && lsq_failed) begin
                    lsq_order_bad = 1'b1;
                end
                if (!lsq_ok[i]) begin
                    lsq_failed = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset) map_zero == '0)
        else $error("x0 no longer maps to physical register 0");

    // Grants never outnumber the registers left in the list
    assert property (@(posedge clk) disable iff (!reset)
                     $countones(reg_pop & reg_ok) <= free_regs)
        else $error("Register granted while the free list was empty");

    assert property (@(posedge clk) disable iff (!reset) !reg_order_bad && !lsq_order_bad)
        else $error("Slot allocated after an older slot of the same kind failed");

endmodule

bind register_alias_table rename_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .map_zero (map_table[0]),
    .reg_pop  (reg_pop),
    .reg_ok   (reg_ok),
    .reg_push (reg_push),
    .lsq_pop  (lsq_pop),
    .lsq_ok   (lsq_ok)
);

// File: dv/rename_tb.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam int RAND_CYCLES = 400;
    // About 460 cycles of reset, directed and random groups, with generous slack
    localparam int MAX_CYCLES  = 1200;

    typedef struct packed {
        ren_slot_t [`RN_WIDTH-1:0] renamed;
        logic      [`RN_WIDTH-1:0] rename_ready;
        logic      [`RN_WIDTH-1:0] lsq_ready;
    } expect_t;

    logic                            clk;
    logic                            reset;
    logic         [`RN_WIDTH-1:0][31:0] words;
    inst_word_u   [`RN_WIDTH-1:0]    inst;
    logic         [`RN_WIDTH-1:0]    inst_valid;
    commit_slot_t [`RN_WIDTH-1:0]    commit;
    logic                            lsq_free_valid;
    lsq_id_t                         lsq_free_slot;
    ren_slot_t    [`RN_WIDTH-1:0]    renamed;
    logic         [`RN_WIDTH-1:0]    rename_ready;
    logic         [`RN_WIDTH-1:0]    lsq_ready;

    // Reference state, with the testbench standing in for the reorder buffer
    phys_reg_t ref_map [`ARCH_REGS];
    phys_reg_t free_q[$];
    lsq_id_t   lsq_q[$];
    phys_reg_t rob_q[$];
    lsq_id_t   lsq_busy[$];
    expect_t   expected;
    int        seed;
    int        cycle_count;
    int        check_count;

    assign inst = words;

    rename_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    function automatic logic [31:0] enc(input logic [6:0] opc, input int rd,
                                        input int rs1, input int rs2);
        // Nonzero funct and immediate bits so stores show their low immediate
        return {7'h15, 5'(rs2), 5'(rs1), 3'b010, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] random_word();
        logic [6:0]  opcs [9] = '{`OPC_LOAD, `OPC_OP_IMM, `OPC_AUIPC, `OPC_STORE, `OPC_OP,
                                  `OPC_LUI, `OPC_BRANCH, `OPC_JALR, `OPC_JAL};
        logic [31:0] w;

        w      = $random(seed);
        w[6:0] = opcs[$unsigned($random(seed)) % 9];
        return w;
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic expect_t rename_model(input logic [`RN_WIDTH-1:0][31:0] w,
                                             input logic [`RN_WIDTH-1:0] v);
        expect_t                       e;
        logic [6:0]                    opc;
        logic                          wr;
        logic                          ls;
        logic [4:0]                    rs1;
        logic [4:0]                    rs2;
        logic [`RN_WIDTH-1:0][4:0]     rd;
        int                            used;
        int                            lused;

        e     = '0;
        used  = 0;
        lused = 0;
        for (int j = 0; j < `RN_WIDTH; j++) begin
            opc   = w[j][6:0];
            wr    = opc inside {`OPC_OP, `OPC_OP_IMM, `OPC_LOAD, `OPC_LUI, `OPC_AUIPC,
                                `OPC_JAL, `OPC_JALR};
            ls    = opc inside {`OPC_LOAD, `OPC_STORE};
            rd[j] = wr ? w[j][11:7] : 5'd0;
            rs1   = (opc inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL}) ? 5'd0 : w[j][19:15];
            rs2   = (opc inside {`OPC_STORE, `OPC_BRANCH, `OPC_OP}) ? w[j][24:20] : 5'd0;
            e.renamed[j].rs1_phys = ref_map[rs1];
            e.renamed[j].rs2_phys = ref_map[rs2];
            // Free entries go to needing slots in order until none remain
            if (v[j] && wr && rd[j] != 5'd0 && used < free_q.size()) begin
                e.renamed[j].rd_valid    = 1'b1;
                e.renamed[j].rd_phys     = free_q[used];
                e.renamed[j].old_rd_phys = ref_map[rd[j]];
                used++;
            end
            if (v[j] && ls && lused < lsq_q.size()) begin
                e.renamed[j].lsq_valid = 1'b1;
                e.renamed[j].lsq_slot  = lsq_q[lused];
                lused++;
            end
            // Oldest first, so the newest older writer is applied last
            for (int k = 0; k < j; k++) begin
                if (e.renamed[k].rd_valid) begin
                    if (rd[k] == rs1) begin
                        e.renamed[j].rs1_phys = e.renamed[k].rd_phys;
                    end
                    if (rd[k] == rs2) begin
                        e.renamed[j].rs2_phys = e.renamed[k].rd_phys;
                    end
                    if (rd[k] == rd[j] && e.renamed[j].rd_valid) begin
                        e.renamed[j].old_rd_phys = e.renamed[k].rd_phys;
                    end
                end
            end
        end
        for (int i = 0; i < `RN_WIDTH; i++) begin
            e.rename_ready[i] = free_q.size() > i;
            e.lsq_ready[i]    = lsq_q.size() > i;
        end
        return e;
    endfunction

    // Applies one group and this cycle's returns, as the next edge will
    task automatic update_model(input expect_t e);
        for (int j = 0; j < `RN_WIDTH; j++) begin
            if (e.renamed[j].rd_valid) begin
                ref_map[words[j][11:7]] = e.renamed[j].rd_phys;
                void'(free_q.pop_front());
                rob_q.push_back(e.renamed[j].old_rd_phys);
            end
            if (e.renamed[j].lsq_valid) begin
                void'(lsq_q.pop_front());
                lsq_busy.push_back(e.renamed[j].lsq_slot);
            end
        end
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (commit[i].valid) begin
                free_q.push_back(commit[i].free_phys);
            end
        end
        if (lsq_free_valid) begin
            lsq_q.push_back(lsq_free_slot);
        end
    endtask

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            expected = rename_model(words, inst_valid);
            for (int j = 0; j < `RN_WIDTH; j++) begin
                check_equal($sformatf("slot %0d renamed", j), 64'(renamed[j]),
                            64'(expected.renamed[j]));
            end
            check_equal("rename_ready", 64'(rename_ready), 64'(expected.rename_ready));
            check_equal("lsq_ready", 64'(lsq_ready), 64'(expected.lsq_ready));
            update_model(expected);
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic drive_group(input logic [`RN_WIDTH-1:0][31:0] w,
                               input logic [`RN_WIDTH-1:0] v,
                               input int n_commit, input bit free_lsq);
        @(posedge clk);
        #1;
        words      = w;
        inst_valid = v;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            commit[i] = '0;
            if (i < n_commit && rob_q.size() > 0) begin
                commit[i].valid     = 1'b1;
                commit[i].free_phys = rob_q.pop_front();
            end
        end
        lsq_free_valid = 1'b0;
        lsq_free_slot  = '0;
        if (free_lsq && lsq_busy.size() > 0) begin
            lsq_free_valid = 1'b1;
            lsq_free_slot  = lsq_busy.pop_front();
        end
    endtask

    initial begin
        seed           = 32'h00fe_e417;
        cycle_count    = 0;
        check_count    = 0;
        reset          = 1'b0;
        words          = '0;
        inst_valid     = '0;
        commit         = '0;
        lsq_free_valid = 1'b0;
        lsq_free_slot  = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            ref_map[i] = phys_reg_t'(i);
            free_q.push_back(phys_reg_t'(`ARCH_REGS + i));
        end
        for (int i = 0; i < `LSQ_SLOTS; i++) begin
            lsq_q.push_back(lsq_id_t'(i));
        end
        repeat (16) @(posedge clk);
        #1 reset = 1'b1;

        drive_group('0, 3'b000, 0, 0);
        // Fresh map, x7 reads p7 and the destinations take p32 to p34
        drive_group({enc(`OPC_LUI, 9, 0, 0), enc(`OPC_OP_IMM, 6, 5, 0),
                     enc(`OPC_OP, 5, 7, 8)}, 3'b111, 0, 0);
        // Both older slots write x10
        drive_group({enc(`OPC_OP, 11, 10, 10), enc(`OPC_OP, 10, 3, 4),
                     enc(`OPC_OP, 10, 1, 2)}, 3'b111, 0, 0);
        // x0 destination, store and branch
        drive_group({enc(`OPC_BRANCH, 3, 6, 11), enc(`OPC_STORE, 9, 5, 10),
                     enc(`OPC_OP, 0, 1, 2)}, 3'b111, 0, 0);
        // Drain the physical list with no commits
        repeat (12) drive_group({enc(`OPC_LUI, 14, 0, 0), enc(`OPC_OP_IMM, 13, 12, 0),
                                 enc(`OPC_OP, 12, 1, 2)}, 3'b111, 0, 0);
        repeat (4) drive_group('0, 3'b000, 3, 0);
        repeat (4) drive_group({enc(`OPC_JAL, 12, 0, 0), enc(`OPC_OP, 12, 12, 13),
                                enc(`OPC_JALR, 13, 12, 0)}, 3'b111, 2, 0);
        // Loads and stores use up the queue, then slots come back
        repeat (4) drive_group({enc(`OPC_LOAD, 16, 15, 0), enc(`OPC_STORE, 0, 2, 15),
                                enc(`OPC_LOAD, 15, 1, 0)}, 3'b111, 3, 0);
        repeat (8) drive_group('0, 3'b000, 0, 1);
        drive_group({enc(`OPC_LOAD, 16, 15, 0), enc(`OPC_STORE, 0, 2, 15),
                     enc(`OPC_LOAD, 15, 1, 0)}, 3'b111, 0, 0);

        repeat (RAND_CYCLES) begin
            drive_group({random_word(), random_word(), random_word()}, 3'($random(seed)),
                        int'($unsigned($random(seed)) % 4), ($random(seed) & 1) != 0);
        end
        drive_group('0, 3'b000, 0, 0);
        @(negedge clk);
        #1;
        if (check_count > 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("No output was ever checked");
            $display("TEST FAILED");
            $fatal(1, "Run ended without checks");
        end
    end

endmodule

// File: build.f
+incdir+include
logic/rename_pkg.sv
logic/rename_decode.sv
logic/free_list.sv
logic/register_alias_table.sv
logic/rename_stage.sv
dv/rename_assert.sv
dv/rename_tb.sv
